//--- verification/ooo_core_testdata.txt
// instruction: 1_op_dest_srca_srcb_imm_useimm_pad, 80 bits, op as in opcode_e
// expected commit: 2_0_arn_value, value 64 bits; one instruction and its commit per line
1_7_01_1f_1f_0005_1_0000000  2_0_01_0000000000000005  // li r1, 5
1_7_02_1f_1f_0007_1_0000000  2_0_02_0000000000000007  // li r2, 7
1_7_03_1f_1f_ffff_1_0000000  2_0_03_ffffffffffffffff  // li r3, -1
1_7_04_1f_1f_1234_1_0000000  2_0_04_0000000000001234  // li r4, 0x1234
1_7_05_1f_1f_0003_1_0000000  2_0_05_0000000000000003  // li r5, 3
1_7_06_1f_1f_00f0_1_0000000  2_0_06_00000000000000f0  // li r6, 0xf0
1_7_07_1f_1f_7fff_1_0000000  2_0_07_0000000000007fff  // li r7, 0x7fff
1_7_08_1f_1f_8000_1_0000000  2_0_08_ffffffffffff8000  // li r8, sign extended
1_0_09_00_00_0011_1_0000000  2_0_09_0000000000000011  // add r9, r0, 0x11
1_3_0a_00_00_0022_1_0000000  2_0_0a_0000000000000022  // or r10, r0, 0x22
1_0_0b_01_02_0000_0_0000000  2_0_0b_000000000000000c  // add r11, r1, r2
1_1_0c_0b_05_0000_0_0000000  2_0_0c_0000000000000009  // sub r12, r11, r5
1_5_0d_0c_00_0004_1_0000000  2_0_0d_0000000000000090  // sll r13, r12, 4
1_2_0e_0d_06_0000_0_0000000  2_0_0e_0000000000000090  // and r14, r13, r6
1_3_0f_0e_04_0000_0_0000000  2_0_0f_00000000000012b4  // or r15, r14, r4
1_4_10_0f_03_0000_0_0000000  2_0_10_ffffffffffffed4b  // xor r16, r15, r3
1_7_11_1f_1f_0064_1_0000000  2_0_11_0000000000000064  // li r17, 100
1_0_12_00_00_0001_1_0000000  2_0_12_0000000000000001  // add r18, r0, 1
1_0_13_11_11_0000_0_0000000  2_0_13_00000000000000c8  // add r19, r17, r17
1_6_14_01_02_0000_0_0000000  2_0_14_0000000000000023  // mul r20, r1, r2
1_0_15_02_00_0001_1_0000000  2_0_15_0000000000000008  // add r21, r2, 1
1_6_16_03_05_0000_0_0000000  2_0_16_fffffffffffffffd  // mul r22, r3, r5
1_0_17_15_15_0000_0_0000000  2_0_17_0000000000000010  // add r23, r21, r21
1_6_18_14_16_0000_0_0000000  2_0_18_ffffffffffffff97  // mul r24, r20, r22
1_6_19_04_04_0000_0_0000000  2_0_19_00000000014b5a90  // mul r25, r4, r4
1_1_1a_19_18_0000_0_0000000  2_0_1a_00000000014b5af9  // sub r26, r25, r24
1_6_1b_08_08_0000_0_0000000  2_0_1b_0000000040000000  // mul r27, r8, r8
1_6_1c_1b_1b_0000_0_0000000  2_0_1c_1000000000000000  // mul r28, r27, r27
1_5_1d_03_00_003f_1_0000000  2_0_1d_8000000000000000  // sll r29, r3, 63
1_0_1e_1d_1d_0000_0_0000000  2_0_1e_0000000000000000  // add r30, r29, r29 wraps
1_7_1f_1f_1f_0055_1_0000000  2_0_1f_0000000000000000  // li r31, 0x55
1_0_1f_01_02_0000_0_0000000  2_0_1f_0000000000000000  // add r31, r1, r2
1_0_01_1f_00_0009_1_0000000  2_0_01_0000000000000009  // add r1, r31, 9
1_3_02_1f_1f_0000_0_0000000  2_0_02_0000000000000000  // or r2, r31, r31
1_0_03_01_00_0001_1_0000000  2_0_03_000000000000000a  // add r3, r1, 1
1_6_04_03_01_0000_0_0000000  2_0_04_000000000000005a  // mul r4, r3, r1
1_1_05_02_04_0000_0_0000000  2_0_05_ffffffffffffffa6  // sub r5, r2, r4
1_0_06_05_04_0000_0_0000000  2_0_06_0000000000000000  // add r6, r5, r4
1_7_07_1f_1f_4321_1_0000000  2_0_07_0000000000004321  // li r7, 0x4321
1_0_07_07_07_0000_0_0000000  2_0_07_0000000000008642  // add r7, r7, r7

//--- vlog.f
logic/ooo_pkg.sv
logic/ooo_intf.sv
logic/rename_map.sv
logic/phys_regfile.sv
logic/reorder_buffer.sv
logic/reservation_station.sv
logic/exec_units.sv
logic/ooo_core.sv
verification/ooo_core_tb.sv

//--- Bender.yml
package:
  name: ooo_core

sources:
  - logic/ooo_pkg.sv
  - logic/ooo_intf.sv
  - logic/rename_map.sv
  - logic/phys_regfile.sv
  - logic/reorder_buffer.sv
  - logic/reservation_station.sv
  - logic/exec_units.sv
  - logic/ooo_core.sv
  - target: test
    files:
      - verification/ooo_core_tb.sv

//--- verification/ooo_core_tb.sv
`timescale 1ns/10ps

module ooo_core_tb;

	localparam int PRF_SIZE    = ooo_pkg::PRF_SIZE;
	localparam int ROB_SIZE    = ooo_pkg::ROB_SIZE;
	localparam int RS_SIZE     = ooo_pkg::RS_SIZE;
	localparam int MULT_STAGES = ooo_pkg::MULT_STAGES;
	localparam int CLK_PERIOD  = 10;
	localparam int MEM_DEPTH   = 256;  // room for the whole data file

	logic                        clock;
	logic                        arst_n;
	logic                        inst_valid, inst_ready;
	ooo_pkg::opcode_e            inst_op;
	ooo_pkg::arn_t               inst_dest, inst_src_a, inst_src_b;
	logic [ooo_pkg::IMM_W-1:0]   inst_imm;
	logic                        inst_use_imm;
	logic                        commit_valid, commit_ready;
	ooo_pkg::arn_t               commit_arn;
	logic [ooo_pkg::DATA_W-1:0]  commit_value;
	logic                        commit_wr_en;

	logic [79:0]  testdata [MEM_DEPTH];  // kind in bits 79:76
	logic [79:0]  inst_q [$];            // instructions still to dispatch
	logic [79:0]  expect_q [$];          // commits in program order
	int           seed;
	int           n_inst, n_expect;
	int           commits_seen;
	int           inflight;              // dispatched but not yet retired
	int           cycle_count, cycle_limit;
	bit           rob_was_full;

	ooo_core #(
		.PRF_SIZE(PRF_SIZE), .ROB_SIZE(ROB_SIZE), .RS_SIZE(RS_SIZE),
		.MULT_STAGES(MULT_STAGES)
	) UUT (
		.clock, .arst_n, .inst_valid, .inst_ready, .inst_op, .inst_dest,
		.inst_src_a, .inst_src_b, .inst_imm, .inst_use_imm, .commit_valid,
		.commit_ready, .commit_arn, .commit_value, .commit_wr_en
	);

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, what, actual,
				expected);
			$display("Some tests failed");
			$fatal(1, "mismatch");
		end
	endtask

	// split the file into the instruction stream and the commit stream
	task automatic load_testdata();
		for (int i = 0; i < MEM_DEPTH; i++) begin
			testdata[i] = '0;  // unused words have kind 0
		end
		$readmemh("verification/ooo_core_testdata.txt", testdata);
		for (int i = 0; i < MEM_DEPTH; i++) begin
			if (testdata[i][79:76] == 4'h1) inst_q.push_back(testdata[i]);
			if (testdata[i][79:76] == 4'h2) expect_q.push_back(testdata[i]);
		end
		n_inst   = inst_q.size();
		n_expect = expect_q.size();
	endtask

	task automatic drive_inst(input logic [79:0] word);
		inst_valid   = 1'b1;
		inst_op      = ooo_pkg::opcode_e'(word[74:72]);
		inst_dest    = word[68:64];
		inst_src_a   = word[60:56];
		inst_src_b   = word[52:48];
		inst_imm     = word[47:32];
		inst_use_imm = word[28];
	endtask

	task automatic check_commit();
		logic [79:0]    expected;
		ooo_pkg::arn_t  exp_arn;
		if (expect_q.size() == 0) begin
			$display("a commit arrived after the whole expected stream had retired");
			$display("Some tests failed");
			$fatal(1, "extra commit");
		end else begin
			expected = expect_q.pop_front();
			exp_arn  = expected[68:64];
			check_value(commit_arn, exp_arn, "commit_arn");
			check_value(commit_wr_en, exp_arn != ooo_pkg::ZERO_REG, "commit_wr_en");
			if (exp_arn != ooo_pkg::ZERO_REG) begin  // zero-reg value is don't care
				check_value(commit_value, expected[63:0], "commit_value");
			end
			commits_seen++;
		end
	endtask

	//////////////////////////////
	// monitor, sampled mid-cycle
	//////////////////////////////
	always @(negedge clock) begin
		if (arst_n) begin
			if (inflight == ROB_SIZE) begin
				rob_was_full = 1'b1;
				check_value(inst_ready, 1'b0, "inst_ready with a full reorder buffer");
			end
			if (commit_valid && commit_ready) check_commit();
			inflight = inflight + int'(inst_valid && inst_ready)
				- int'(commit_valid && commit_ready);
		end
	end

	// random back-pressure, ready about one cycle in four
	initial begin
		seed         = 96945;
		commit_ready = 1'b0;
		@(posedge arst_n);
		forever begin
			@(posedge clock);
			#1;
			commit_ready = ($random(seed) & 3) == 0;
		end
	end

	// cycle budget scales with the program length
	initial begin
		cycle_count = 0;
		wait (cycle_limit > 0 && arst_n);
		while (cycle_count < cycle_limit) begin
			@(posedge clock);
			cycle_count++;
		end
		$display("timeout after %0d cycles, the core stopped committing", cycle_count);
		$display("Some tests failed");
		$fatal(1, "timeout");
	end

	//////////////////////////////
	// dispatch and end of run
	//////////////////////////////
	initial begin
		arst_n       = 1'b0;
		inst_valid   = 1'b0;
		inst_op      = ooo_pkg::op_add;
		inst_dest    = '0;
		inst_src_a   = '0;
		inst_src_b   = '0;
		inst_imm     = '0;
		inst_use_imm = 1'b0;
		commits_seen = 0;
		inflight     = 0;
		rob_was_full = 1'b0;
		cycle_limit  = 0;
		load_testdata();
		if (n_inst == 0 || n_inst != n_expect) begin
			$display("test data holds %0d instructions and %0d commits", n_inst, n_expect);
			$display("Some tests failed");
			$fatal(1, "bad test data");
		end
		cycle_limit = 10 * n_inst + 100;
		repeat (4) @(posedge clock);
		#1 arst_n = 1'b1;
		@(negedge clock);
		check_value(inst_ready, 1'b1, "inst_ready after reset");
		check_value(commit_valid, 1'b0, "commit_valid after reset");
		while (inst_q.size() > 0) begin
			@(posedge clock);
			#1;
			drive_inst(inst_q[0]);
			@(negedge clock);
			if (inst_ready) void'(inst_q.pop_front());  // taken at the next edge
		end
		@(posedge clock);
		#1 inst_valid = 1'b0;
		wait (commits_seen == n_expect);
		@(negedge clock);
		check_value(commit_valid, 1'b0, "commit_valid after the last commit");
		if (!rob_was_full) begin
			$display("the reorder buffer never filled, back-pressure was not exercised");
			$display("Some tests failed");
			$fatal(1, "no back-pressure");
		end else begin
			$display("All tests passed");
			$finish;
		end
	end

endmodule

//--- logic/ooo_core.sv
`timescale 1ns/10ps

module ooo_core #(
	parameter int PRF_SIZE    = ooo_pkg::PRF_SIZE,
	parameter int ROB_SIZE    = ooo_pkg::ROB_SIZE,
	parameter int RS_SIZE     = ooo_pkg::RS_SIZE,
	parameter int MULT_STAGES = ooo_pkg::MULT_STAGES
) (
	input  logic                        clock,
	input  logic                        arst_n,
	input  logic                        inst_valid,
	output logic                        inst_ready,
	input  ooo_pkg::opcode_e            inst_op,
	input  ooo_pkg::arn_t               inst_dest,
	input  ooo_pkg::arn_t               inst_src_a,
	input  ooo_pkg::arn_t               inst_src_b,
	input  logic [ooo_pkg::IMM_W-1:0]   inst_imm,
	input  logic                        inst_use_imm,
	output logic                        commit_valid,
	input  logic                        commit_ready,
	output ooo_pkg::arn_t               commit_arn,
	output logic [ooo_pkg::DATA_W-1:0]  commit_value,
	output logic                        commit_wr_en
);
	logic                        dispatch_fire;
	ooo_pkg::uop_t               dispatch_uop;
	logic                        rs_space, rob_space;
	logic                        free_valid;
	ooo_pkg::prn_t               free_prn;
	ooo_pkg::rob_idx_t           tail_idx;
	logic [ooo_pkg::DATA_W-1:0]  opa_value, opb_value;
	logic                        opa_ready, opb_ready;

	cdb_if   cdb ();
	issue_if alu_issue ();
	issue_if mul_issue ();

	//////////////////////////////
	// rename and dispatch
	//////////////////////////////
	rename_map #(.PRF_SIZE(PRF_SIZE)) rename (
		.clock, .arst_n, .inst_valid, .inst_ready, .inst_op, .inst_dest,
		.inst_src_a, .inst_src_b, .inst_imm, .inst_use_imm, .rs_space, .rob_space,
		.free_valid, .free_prn, .dispatch_fire, .dispatch_uop
	);

	phys_regfile #(.PRF_SIZE(PRF_SIZE)) prf (
		.clock, .arst_n, .dispatch_fire, .dispatch_uop, .cdb(cdb.sink),
		.opa_value, .opa_ready, .opb_value, .opb_ready
	);

	reorder_buffer #(.ROB_SIZE(ROB_SIZE)) rob (
		.clock, .arst_n, .dispatch_fire, .dispatch_uop, .cdb(cdb.sink), .commit_ready,
		.rob_space, .tail_idx, .commit_valid, .commit_arn, .commit_value,
		.commit_wr_en, .free_valid, .free_prn
	);

	//////////////////////////////
	// issue and execute
	//////////////////////////////
	reservation_station #(.RS_SIZE(RS_SIZE)) rs (
		.clock, .arst_n, .dispatch_fire, .dispatch_uop, .tail_idx,
		.opa_value, .opa_ready, .opb_value, .opb_ready, .cdb(cdb.sink),
		.rs_space, .alu_issue(alu_issue.src), .mul_issue(mul_issue.src)
	);

	exec_units #(.MULT_STAGES(MULT_STAGES)) ex (
		.clock, .arst_n, .alu_issue(alu_issue.sink), .mul_issue(mul_issue.sink),
		.cdb(cdb.src)
	);

endmodule

//--- logic/exec_units.sv
`timescale 1ns/10ps

module exec_units #(
	parameter int MULT_STAGES = ooo_pkg::MULT_STAGES
) (
	input  logic  clock,
	input  logic  arst_n,
	issue_if.sink alu_issue,
	issue_if.sink mul_issue,
	cdb_if.src    cdb
);
	localparam int LAST = MULT_STAGES - 1;

	logic                        alu_v;
	ooo_pkg::prn_t               alu_prn;
	ooo_pkg::rob_idx_t           alu_rob;
	logic [ooo_pkg::DATA_W-1:0]  alu_res, alu_out;
	logic [MULT_STAGES-1:0]      mul_v;  // bit 0 is the newest
	ooo_pkg::prn_t               mul_prn  [MULT_STAGES];
	ooo_pkg::rob_idx_t           mul_rob  [MULT_STAGES];
	logic [ooo_pkg::DATA_W-1:0]  mul_prod [MULT_STAGES];

	always_comb begin
		case (alu_issue.op)
			ooo_pkg::op_add: alu_out = alu_issue.opa + alu_issue.opb;
			ooo_pkg::op_sub: alu_out = alu_issue.opa - alu_issue.opb;
			ooo_pkg::op_and: alu_out = alu_issue.opa & alu_issue.opb;
			ooo_pkg::op_or:  alu_out = alu_issue.opa | alu_issue.opb;
			ooo_pkg::op_xor: alu_out = alu_issue.opa ^ alu_issue.opb;
			ooo_pkg::op_sll: alu_out = alu_issue.opa << alu_issue.opb[5:0];
			ooo_pkg::op_li:  alu_out = alu_issue.opb;  // imm already extended
			default:         alu_out = '0;
		endcase
	end

	// the next bus slot belongs to a multiply in that case
	assign alu_issue.ready = !mul_v[LAST-1];
	assign mul_issue.ready = 1'b1;  // pipeline never stalls

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			alu_v <= 1'b0;
			mul_v <= '0;
		end else begin
			alu_v <= alu_issue.valid && alu_issue.ready;
			mul_v <= {mul_v[LAST-1:0], mul_issue.valid};
		end
	end

	always_ff @(posedge clock) begin
		alu_res     <= alu_out;
		alu_prn     <= alu_issue.dest_prn;
		alu_rob     <= alu_issue.rob_idx;
		mul_prod[0] <= mul_issue.opa * mul_issue.opb;  // low 64 bits of the product
		mul_prn[0]  <= mul_issue.dest_prn;
		mul_rob[0]  <= mul_issue.rob_idx;
		for (int k = 1; k < MULT_STAGES; k++) begin
			mul_prod[k] <= mul_prod[k-1];
			mul_prn[k]  <= mul_prn[k-1];
			mul_rob[k]  <= mul_rob[k-1];
		end
	end

	// single bus, multiplier first
	assign cdb.valid   = mul_v[LAST] || alu_v;
	assign cdb.prn     = mul_v[LAST] ? mul_prn[LAST]  : alu_prn;
	assign cdb.value   = mul_v[LAST] ? mul_prod[LAST] : alu_res;
	assign cdb.rob_idx = mul_v[LAST] ? mul_rob[LAST]  : alu_rob;

endmodule

//--- logic/reservation_station.sv
`timescale 1ns/10ps

module reservation_station #(
	parameter int RS_SIZE = ooo_pkg::RS_SIZE
) (
	input  logic                        clock,
	input  logic                        arst_n,
	input  logic                        dispatch_fire,
	input  ooo_pkg::uop_t               dispatch_uop,
	input  ooo_pkg::rob_idx_t           tail_idx,
	input  logic [ooo_pkg::DATA_W-1:0]  opa_value,
	input  logic                        opa_ready,
	input  logic [ooo_pkg::DATA_W-1:0]  opb_value,
	input  logic                        opb_ready,
	cdb_if.sink                         cdb,
	output logic                        rs_space,
	issue_if.src                        alu_issue,
	issue_if.src                        mul_issue
);
	localparam int IDX_W = $clog2(RS_SIZE);

	typedef enum logic [1:0] {slot_empty, slot_waiting, slot_ready} slot_state_e;

	slot_state_e                 state [RS_SIZE];
	ooo_pkg::opcode_e            op    [RS_SIZE];
	logic [ooo_pkg::DATA_W-1:0]  a_val [RS_SIZE];
	logic [ooo_pkg::DATA_W-1:0]  b_val [RS_SIZE];
	ooo_pkg::prn_t               a_tag [RS_SIZE];
	ooo_pkg::prn_t               b_tag [RS_SIZE];
	ooo_pkg::prn_t               dest  [RS_SIZE];
	ooo_pkg::rob_idx_t           rob   [RS_SIZE];
	logic [RS_SIZE-1:0]          a_rdy, b_rdy;
	logic [RS_SIZE-1:0]          a_wake, b_wake;  // bus matches a waiting tag
	logic [IDX_W-1:0]            free_idx, alu_idx, mul_idx;
	logic                        alu_ok, mul_ok;
	logic                        alu_go, mul_go;
	logic                        b_in_rdy;
	logic [ooo_pkg::DATA_W-1:0]  b_in_val;

	//////////////////////////////
	// slot select and wakeup
	//////////////////////////////
	always_comb begin
		rs_space = 1'b0;
		alu_ok   = 1'b0;
		mul_ok   = 1'b0;
		free_idx = '0;
		alu_idx  = '0;
		mul_idx  = '0;
		for (int i = RS_SIZE - 1; i >= 0; i--) begin  // lowest index wins
			if (state[i] == slot_empty) begin
				rs_space = 1'b1;
				free_idx = IDX_W'(i);
			end
			if (state[i] == slot_ready && op[i] == ooo_pkg::op_mul) begin
				mul_ok  = 1'b1;
				mul_idx = IDX_W'(i);
			end
			if (state[i] == slot_ready && op[i] != ooo_pkg::op_mul) begin
				alu_ok  = 1'b1;
				alu_idx = IDX_W'(i);
			end
		end
		for (int i = 0; i < RS_SIZE; i++) begin
			a_wake[i] = state[i] == slot_waiting && cdb.valid && !a_rdy[i] && cdb.prn == a_tag[i];
			b_wake[i] = state[i] == slot_waiting && cdb.valid && !b_rdy[i] && cdb.prn == b_tag[i];
		end
	end

	assign b_in_rdy = dispatch_uop.imm_b || opb_ready;
	assign b_in_val = dispatch_uop.imm_b ?
		{{(ooo_pkg::DATA_W - ooo_pkg::IMM_W){dispatch_uop.imm[ooo_pkg::IMM_W-1]}},
		dispatch_uop.imm} : opb_value;  // sign-extend the immediate

	//////////////////////////////
	// issue ports
	//////////////////////////////
	assign alu_issue.valid    = alu_ok;
	assign alu_issue.op       = op[alu_idx];
	assign alu_issue.opa      = a_val[alu_idx];
	assign alu_issue.opb      = b_val[alu_idx];
	assign alu_issue.dest_prn = dest[alu_idx];
	assign alu_issue.rob_idx  = rob[alu_idx];
	assign mul_issue.valid    = mul_ok;
	assign mul_issue.op       = op[mul_idx];
	assign mul_issue.opa      = a_val[mul_idx];
	assign mul_issue.opb      = b_val[mul_idx];
	assign mul_issue.dest_prn = dest[mul_idx];
	assign mul_issue.rob_idx  = rob[mul_idx];
	assign alu_go = alu_issue.valid && alu_issue.ready;
	assign mul_go = mul_issue.valid && mul_issue.ready;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < RS_SIZE; i++) begin
				state[i] <= slot_empty;
			end
		end else begin
			for (int i = 0; i < RS_SIZE; i++) begin
				if (dispatch_fire && free_idx == IDX_W'(i)) begin
					state[i] <= (opa_ready && b_in_rdy) ? slot_ready : slot_waiting;
				end else if ((alu_go && alu_idx == IDX_W'(i)) || (mul_go && mul_idx == IDX_W'(i))) begin
					state[i] <= slot_empty;  // handed to its unit
				end else if (state[i] == slot_waiting && (a_rdy[i] || a_wake[i])
						&& (b_rdy[i] || b_wake[i])) begin
					state[i] <= slot_ready;  // may issue next cycle
				end
			end
		end
	end

	// operands, tags and payload
	always_ff @(posedge clock) begin
		for (int i = 0; i < RS_SIZE; i++) begin
			if (dispatch_fire && free_idx == IDX_W'(i)) begin
				op[i]    <= dispatch_uop.op;
				a_val[i] <= opa_value;
				a_rdy[i] <= opa_ready;
				a_tag[i] <= dispatch_uop.src_a;
				b_val[i] <= b_in_val;
				b_rdy[i] <= b_in_rdy;
				b_tag[i] <= dispatch_uop.src_b;
				dest[i]  <= dispatch_uop.dest_prn;
				rob[i]   <= tail_idx;
			end else begin
				if (a_wake[i]) begin
					a_val[i] <= cdb.value;
					a_rdy[i] <= 1'b1;
				end
				if (b_wake[i]) begin
					b_val[i] <= cdb.value;
					b_rdy[i] <= 1'b1;
				end
			end
		end
	end

endmodule

//--- logic/reorder_buffer.sv
`timescale 1ns/10ps

module reorder_buffer #(
	parameter int ROB_SIZE = ooo_pkg::ROB_SIZE
) (
	input  logic                        clock,
	input  logic                        arst_n,
	input  logic                        dispatch_fire,
	input  ooo_pkg::uop_t               dispatch_uop,
	cdb_if.sink                         cdb,
	input  logic                        commit_ready,
	output logic                        rob_space,
	output ooo_pkg::rob_idx_t           tail_idx,      // entry given to this dispatch
	output logic                        commit_valid,
	output ooo_pkg::arn_t               commit_arn,
	output logic [ooo_pkg::DATA_W-1:0]  commit_value,
	output logic                        commit_wr_en,
	output logic                        free_valid,
	output ooo_pkg::prn_t               free_prn
);
	ooo_pkg::arn_t               arn   [ROB_SIZE];
	ooo_pkg::prn_t               prev  [ROB_SIZE];
	logic [ooo_pkg::DATA_W-1:0]  value [ROB_SIZE];
	logic [ROB_SIZE-1:0]         done;
	ooo_pkg::rob_idx_t           head;
	ooo_pkg::rob_idx_t           tail;
	logic [$clog2(ROB_SIZE+1)-1:0] count;
	logic                        commit_fire;

	function automatic ooo_pkg::rob_idx_t next_idx(input ooo_pkg::rob_idx_t idx);
		return (idx == ooo_pkg::rob_idx_t'(ROB_SIZE - 1)) ? '0 : idx + 1'b1;  // wrap
	endfunction

	assign rob_space    = count != ROB_SIZE;
	assign tail_idx     = tail;
	assign commit_valid = (count != 0) && done[head];
	assign commit_fire  = commit_valid && commit_ready;
	assign commit_arn   = arn[head];
	assign commit_value = value[head];
	assign commit_wr_en = arn[head] != ooo_pkg::ZERO_REG;
	assign free_valid   = commit_fire && commit_wr_en;  // zero-reg writes hold no prn
	assign free_prn     = prev[head];

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
			done  <= '0;
		end else begin
			if (dispatch_fire) begin
				tail       <= next_idx(tail);
				done[tail] <= 1'b0;
			end
			if (cdb.valid) begin
				done[cdb.rob_idx] <= 1'b1;  // completes the cycle after the bus
			end
			if (commit_fire) begin
				head <= next_idx(head);
			end
			if (dispatch_fire && !commit_fire) begin
				count <= count + 1'b1;
			end else if (commit_fire && !dispatch_fire) begin
				count <= count - 1'b1;
			end
		end
	end

	// entry payload
	always_ff @(posedge clock) begin
		if (dispatch_fire) begin
			arn[tail]  <= dispatch_uop.dest_arn;
			prev[tail] <= dispatch_uop.prev_prn;
		end
		if (cdb.valid) begin
			value[cdb.rob_idx] <= cdb.value;
		end
	end

endmodule

//--- logic/phys_regfile.sv
`timescale 1ns/10ps

module phys_regfile #(
	parameter int PRF_SIZE = ooo_pkg::PRF_SIZE
) (
	input  logic                        clock,
	input  logic                        arst_n,
	input  logic                        dispatch_fire,
	input  ooo_pkg::uop_t               dispatch_uop,
	cdb_if.sink                         cdb,
	output logic [ooo_pkg::DATA_W-1:0]  opa_value,
	output logic                        opa_ready,
	output logic [ooo_pkg::DATA_W-1:0]  opb_value,
	output logic                        opb_ready
);
	logic [ooo_pkg::DATA_W-1:0]  values [PRF_SIZE];
	logic [PRF_SIZE-1:0]         ready;
	logic                        wr_en;

	// prn 31 backs the zero register, results aimed at it are dropped
	assign wr_en = cdb.valid && (cdb.prn != ooo_pkg::prn_t'(ooo_pkg::ZERO_REG));

	// read ports with same-cycle bus bypass
	always_comb begin
		opa_value = values[dispatch_uop.src_a];
		opa_ready = ready[dispatch_uop.src_a];
		if (wr_en && cdb.prn == dispatch_uop.src_a) begin
			opa_value = cdb.value;
			opa_ready = 1'b1;
		end
		opb_value = values[dispatch_uop.src_b];
		opb_ready = ready[dispatch_uop.src_b];
		if (wr_en && cdb.prn == dispatch_uop.src_b) begin
			opb_value = cdb.value;
			opb_ready = 1'b1;
		end
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			ready <= '1;  // every register starts valid at zero
			for (int i = 0; i < PRF_SIZE; i++) begin
				values[i] <= '0;
			end
		end else begin
			if (dispatch_fire && dispatch_uop.has_dest) begin
				ready[dispatch_uop.dest_prn] <= 1'b0;  // pending until its result
			end
			if (wr_en) begin
				values[cdb.prn] <= cdb.value;
				ready[cdb.prn]  <= 1'b1;
			end
		end
	end

endmodule

//--- logic/rename_map.sv
`timescale 1ns/10ps

module rename_map #(
	parameter int PRF_SIZE = ooo_pkg::PRF_SIZE
) (
	input  logic                       clock,
	input  logic                       arst_n,
	input  logic                       inst_valid,
	output logic                       inst_ready,
	input  ooo_pkg::opcode_e           inst_op,
	input  ooo_pkg::arn_t              inst_dest,
	input  ooo_pkg::arn_t              inst_src_a,
	input  ooo_pkg::arn_t              inst_src_b,
	input  logic [ooo_pkg::IMM_W-1:0]  inst_imm,
	input  logic                       inst_use_imm,
	input  logic                       rs_space,      // station has an empty slot
	input  logic                       rob_space,     // rob not full
	input  logic                       free_valid,    // commit returns a prn
	input  ooo_pkg::prn_t              free_prn,
	output logic                       dispatch_fire,
	output ooo_pkg::uop_t              dispatch_uop
);
	ooo_pkg::prn_t        alias_table [ooo_pkg::ARF_SIZE];  // arn -> current prn
	logic [PRF_SIZE-1:0]  free_list;                        // one bit per prn, 1 = free
	ooo_pkg::prn_t        alloc_prn;
	logic                 alloc_ok;
	logic                 has_dest;

	// lowest free prn, loop runs downward so the lowest wins
	always_comb begin
		alloc_ok  = 1'b0;
		alloc_prn = '0;
		for (int i = PRF_SIZE - 1; i >= 0; i--) begin
			if (free_list[i]) begin
				alloc_ok  = 1'b1;
				alloc_prn = ooo_pkg::prn_t'(i);
			end
		end
	end

	assign has_dest      = inst_dest != ooo_pkg::ZERO_REG;
	assign inst_ready    = rs_space && rob_space && (alloc_ok || !has_dest);
	assign dispatch_fire = inst_valid && inst_ready;

	always_comb begin
		dispatch_uop.op       = inst_op;
		dispatch_uop.src_a    = alias_table[inst_src_a];  // r31 stays on prn 31
		dispatch_uop.src_b    = alias_table[inst_src_b];
		dispatch_uop.imm      = inst_imm;
		dispatch_uop.dest_prn = has_dest ? alloc_prn : ooo_pkg::prn_t'(ooo_pkg::ZERO_REG);
		dispatch_uop.prev_prn = alias_table[inst_dest];
		dispatch_uop.dest_arn = inst_dest;
		dispatch_uop.has_dest = has_dest;
		dispatch_uop.imm_b    = inst_use_imm || (inst_op == ooo_pkg::op_li);  // li always takes imm
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < ooo_pkg::ARF_SIZE; i++) begin
				alias_table[i] <= ooo_pkg::prn_t'(i);  // identity map
			end
			for (int i = 0; i < PRF_SIZE; i++) begin
				free_list[i] <= (i >= ooo_pkg::ARF_SIZE);
			end
		end else begin
			if (free_valid) begin
				free_list[free_prn] <= 1'b1;  // never the prn allocated below
			end
			if (dispatch_fire && has_dest) begin
				alias_table[inst_dest] <= alloc_prn;
				free_list[alloc_prn]   <= 1'b0;
			end
		end
	end

endmodule

//--- logic/ooo_intf.sv
`timescale 1ns/10ps

// station to one execution unit, valid/ready
interface issue_if;
	logic                        valid;
	logic                        ready;
	ooo_pkg::opcode_e            op;
	logic [ooo_pkg::DATA_W-1:0]  opa;
	logic [ooo_pkg::DATA_W-1:0]  opb;
	ooo_pkg::prn_t               dest_prn;
	ooo_pkg::rob_idx_t           rob_idx;

	modport src (
		output valid, op, opa, opb, dest_prn, rob_idx,
		input  ready
	);
	modport sink (
		input  valid, op, opa, opb, dest_prn, rob_idx,
		output ready
	);
endinterface

// common data bus, one result per cycle
interface cdb_if;
	logic                        valid;
	ooo_pkg::prn_t               prn;
	logic [ooo_pkg::DATA_W-1:0]  value;
	ooo_pkg::rob_idx_t           rob_idx;

	modport src  (output valid, prn, value, rob_idx);
	modport sink (input  valid, prn, value, rob_idx);
endinterface

//--- logic/ooo_pkg.sv
package ooo_pkg;

	parameter int DATA_W      = 64;  // datapath width
	parameter int ARF_SIZE    = 32;  // architected registers
	parameter int PRF_SIZE    = 64;  // physical registers, default only
	parameter int ROB_SIZE    = 16;  // reorder buffer entries, default only
	parameter int RS_SIZE     = 8;   // station slots, default only
	parameter int MULT_STAGES = 4;   // multiplier latency, default only
	parameter int IMM_W       = 16;  // immediate field width

	typedef logic [$clog2(ARF_SIZE)-1:0] arn_t;    // architected index
	typedef logic [$clog2(PRF_SIZE)-1:0] prn_t;    // physical index
	typedef logic [$clog2(ROB_SIZE)-1:0] rob_idx_t;

	parameter arn_t ZERO_REG = arn_t'(31);  // reads zero, never renamed

	typedef enum logic [2:0] {
		op_add,
		op_sub,
		op_and,
		op_or,
		op_xor,
		op_sll,  // shift by low 6 bits of b
		op_mul,  // only op that goes to the multiplier
		op_li    // sign-extended immediate
	} opcode_e;

	typedef struct packed {
		opcode_e          op;
		prn_t             src_a;
		prn_t             src_b;
		logic [IMM_W-1:0] imm;
		prn_t             dest_prn;  // newly allocated prn
		prn_t             prev_prn;  // old mapping, freed at commit
		arn_t             dest_arn;
		logic             has_dest;  // dest is not the zero register
		logic             imm_b;     // operand b is the immediate
	} uop_t;

endpackage
